// ==== hw/aa_ctrl_consts.svh ====
/*
 * AA register controller constants
 * Bus widths, local address windows, mailbox sizing and the
 * AXI-Stream tuser tag used by remote mailbox writes.
 */

`ifndef AA_CTRL_CONSTS_SVH
`define AA_CTRL_CONSTS_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define AA_DATA_W       32
`define AA_STRB_W       4
`define AA_LS_ADDR_W    15
`define AA_SS_ADDR_W    28

// ----------------------------------------------------------------------
// local address map
// ----------------------------------------------------------------------
`define AA_MB_LOW       15'h2000
`define AA_MB_HIGH      15'h201F
`define AA_AA_LOW       15'h2100
`define AA_AA_HIGH      15'h2107
// top of the local MB/AA range, the rest above 0x2107 is unsupported
`define AA_UNSUPP_HIGH  15'h2FFF

// mailbox sizing
`define AA_MB_COUNT     8
`define AA_IDX_W        3

// remote beat tag and read-back filler
`define AA_TUSER_WRITE  2'b01
`define AA_ALL_ONES     32'hFFFF_FFFF

`endif

// ==== hw/aa_ctrl_decode.sv ====
/*
 * AA register controller, decode stage
 * Round-robin choice between the AXI-Lite and AXI-Stream backends,
 * two-beat capture of remote mailbox writes, and address decode
 * into a single operation pulse for the execute stage.
 */

`timescale 1ns/1ns

`include "aa_ctrl_consts.svh"

module aa_ctrl_decode (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    input  logic                   bk_ls_valid,
    input  logic                   bk_ls_rd_wr,
    input  aa_ctrl_pkg::ls_addr_t  bk_ls_addr,
    input  aa_ctrl_pkg::data_t     bk_ls_wdata,
    input  aa_ctrl_pkg::strb_t     bk_ls_wstrb,
    input  logic                   bk_ss_valid,
    input  aa_ctrl_pkg::data_t     bk_ss_data,
    input  logic [1:0]             bk_ss_user,
    input  logic                   ls_done,
    input  logic                   ss_done,
    output logic                   ss_hdr_ready,
    output logic                   op_valid,
    output aa_ctrl_pkg::op_e       op_kind,
    output aa_ctrl_pkg::src_e      op_src,
    output aa_ctrl_pkg::mb_idx_t   op_idx,
    output aa_ctrl_pkg::data_t     op_wdata,
    output aa_ctrl_pkg::strb_t     op_wstrb
);

    typedef enum logic [2:0] {
        st_idle,
        st_ls,
        st_ss_hdr,
        st_ss_wait,
        st_issue,
        st_busy
    } state_e;

    state_e                  state;
    aa_ctrl_pkg::src_e       last_src;
    logic                    pick_ls;
    logic                    pick_ss;
    logic                    ls_in_mb;
    logic                    ls_in_aa;
    aa_ctrl_pkg::op_e        ls_kind;
    logic [`AA_SS_ADDR_W-1:0] hdr_addr;
    logic                    hdr_in_mb;

    // ------------------------------------------------------------------
    // round robin, the side served last loses a tie
    // ------------------------------------------------------------------
    assign pick_ls = bk_ls_valid && (!bk_ss_valid || last_src == aa_ctrl_pkg::src_ss);
    assign pick_ss = bk_ss_valid && !pick_ls;

    // local address windows
    assign ls_in_mb = (bk_ls_addr >= `AA_MB_LOW) && (bk_ls_addr <= `AA_MB_HIGH);
    assign ls_in_aa = (bk_ls_addr >= `AA_AA_LOW) && (bk_ls_addr <= `AA_AA_HIGH);

    always_comb begin
        if (bk_ls_rd_wr) begin
            if (ls_in_mb) begin
                ls_kind = aa_ctrl_pkg::op_rd_mb;
            end else if (ls_in_aa) begin
                ls_kind = aa_ctrl_pkg::op_rd_aa;
            end else begin
                // unsupported or outside the windows, both read as all ones
                ls_kind = aa_ctrl_pkg::op_rd_unsupp;
            end
        end else begin
            if (ls_in_mb) begin
                ls_kind = aa_ctrl_pkg::op_wr_mb;
            end else if (ls_in_aa) begin
                ls_kind = aa_ctrl_pkg::op_wr_aa;
            end else begin
                ls_kind = aa_ctrl_pkg::op_ignore;
            end
        end
    end

    // remote header, only the mailbox window is writable
    assign hdr_addr  = bk_ss_data[`AA_SS_ADDR_W-1:0];
    assign hdr_in_mb = (hdr_addr >= `AA_SS_ADDR_W'(`AA_MB_LOW)) &&
                       (hdr_addr <= `AA_SS_ADDR_W'(`AA_MB_HIGH));

    // ------------------------------------------------------------------
    // request FSM
    // ------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state    <= st_idle;
            last_src <= aa_ctrl_pkg::src_ss;
            op_kind  <= aa_ctrl_pkg::op_ignore;
            op_src   <= aa_ctrl_pkg::src_ls;
            op_idx   <= '0;
            op_wdata <= '0;
            op_wstrb <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (pick_ls) begin
                        state    <= st_ls;
                        last_src <= aa_ctrl_pkg::src_ls;
                        op_src   <= aa_ctrl_pkg::src_ls;
                        op_kind  <= ls_kind;
                        op_idx   <= bk_ls_addr[`AA_IDX_W+1:2];
                        op_wdata <= bk_ls_wdata;
                        op_wstrb <= bk_ls_wstrb;
                    end else if (pick_ss) begin
                        last_src <= aa_ctrl_pkg::src_ss;
                        op_src   <= aa_ctrl_pkg::src_ss;
                        if (bk_ss_user == `AA_TUSER_WRITE) begin
                            state <= st_ss_hdr;
                        end else begin
                            // unknown tag, swallow this beat only
                            state    <= st_issue;
                            op_kind  <= aa_ctrl_pkg::op_ignore;
                            op_wdata <= '0;
                            op_wstrb <= '0;
                        end
                    end
                end
                st_ls: begin
                    state <= st_busy;
                end
                st_ss_hdr: begin
                    // header taken at the end of the ready cycle
                    op_kind  <= hdr_in_mb ? aa_ctrl_pkg::op_wr_mb : aa_ctrl_pkg::op_ignore;
                    op_idx   <= hdr_addr[`AA_IDX_W+1:2];
                    op_wstrb <= bk_ss_data[`AA_DATA_W-1 -: `AA_STRB_W];
                    state    <= st_ss_wait;
                end
                st_ss_wait: begin
                    if (bk_ss_valid) begin
                        op_wdata <= bk_ss_data;
                        state    <= st_issue;
                    end
                end
                st_issue: begin
                    state <= st_busy;
                end
                st_busy: begin
                    if (ls_done || ss_done) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign op_valid     = (state == st_ls) || (state == st_issue);
    assign ss_hdr_ready = (state == st_ss_hdr);

endmodule

// ==== hw/aa_ctrl_execute.sv ====
/*
 * AA register controller, execute stage
 * Mailbox and AA control registers, strobed write application,
 * read data selection and the interrupt line.
 */

`timescale 1ns/1ns

`include "aa_ctrl_consts.svh"

module aa_ctrl_execute (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    input  logic                   op_valid,
    input  aa_ctrl_pkg::op_e       op_kind,
    input  aa_ctrl_pkg::src_e      op_src,
    input  aa_ctrl_pkg::mb_idx_t   op_idx,
    input  aa_ctrl_pkg::data_t     op_wdata,
    input  aa_ctrl_pkg::strb_t     op_wstrb,
    output logic                   exec_done,
    output aa_ctrl_pkg::data_t     exec_rdata,
    output aa_ctrl_pkg::src_e      exec_src,
    output logic                   axi_interrupt
);

    // mailbox words, dword addressed from 0x2000
    aa_ctrl_pkg::data_t mb_regs [`AA_MB_COUNT];

    // AA register bit 0 of offsets 0 and 4
    logic               int_en;
    logic               int_sts;
    aa_ctrl_pkg::data_t rd_value;
    logic               aa_bit;

    // ------------------------------------------------------------------
    // read selection
    // ------------------------------------------------------------------
    assign aa_bit = op_idx[0] ? int_sts : int_en;

    always_comb begin
        case (op_kind)
            aa_ctrl_pkg::op_rd_mb: begin
                rd_value = mb_regs[op_idx];
            end
            aa_ctrl_pkg::op_rd_aa: begin
                // upper bits read as zero
                rd_value = {{(`AA_DATA_W-1){1'b0}}, aa_bit};
            end
            aa_ctrl_pkg::op_rd_unsupp: begin
                rd_value = `AA_ALL_ONES;
            end
            default: begin
                rd_value = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // register updates
    // ------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < `AA_MB_COUNT; i++) begin
                mb_regs[i] <= '0;
            end
            int_en     <= 1'b0;
            int_sts    <= 1'b0;
            exec_done  <= 1'b0;
            exec_rdata <= '0;
            exec_src   <= aa_ctrl_pkg::src_ls;
        end else begin
            exec_done <= op_valid;
            if (op_valid) begin
                exec_src   <= op_src;
                exec_rdata <= rd_value;
                case (op_kind)
                    aa_ctrl_pkg::op_wr_mb: begin
                        for (int b = 0; b < `AA_STRB_W; b++) begin
                            if (op_wstrb[b]) begin
                                mb_regs[op_idx][8*b +: 8] <= op_wdata[8*b +: 8];
                            end
                        end
                        // remote mailbox write flags the local side, enable or not
                        if (op_src == aa_ctrl_pkg::src_ss) begin
                            int_sts <= 1'b1;
                        end
                    end
                    aa_ctrl_pkg::op_wr_aa: begin
                        if (op_wstrb[0]) begin
                            if (!op_idx[0]) begin
                                int_en <= op_wdata[0];
                            end else if (op_wdata[0]) begin
                                // write one to clear
                                int_sts <= 1'b0;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign axi_interrupt = int_en & int_sts;

endmodule

// ==== hw/aa_ctrl_pkg.sv ====
/*
 * AA register controller package
 * Bus word, strobe, address and index types plus the operation
 * and source encodings passed between the pipeline stages.
 */

`include "aa_ctrl_consts.svh"

package aa_ctrl_pkg;

    typedef logic [`AA_DATA_W-1:0]    data_t;
    typedef logic [`AA_STRB_W-1:0]    strb_t;
    typedef logic [`AA_LS_ADDR_W-1:0] ls_addr_t;
    typedef logic [`AA_IDX_W-1:0]     mb_idx_t;

    // requester that issued an operation
    typedef enum logic {
        src_ls = 1'b0,
        src_ss = 1'b1
    } src_e;

    // decoded operation, zero is the harmless one
    typedef enum logic [2:0] {
        op_wr_mb     = 3'd1,
        op_rd_mb     = 3'd2,
        op_wr_aa     = 3'd3,
        op_rd_aa     = 3'd4,
        op_rd_unsupp = 3'd5,
        op_ignore    = 3'd0
    } op_e;

endpackage

// ==== hw/aa_ctrl_result.sv ====
/*
 * AA register controller, result stage
 * Turns the execute completion into a ready pulse toward the
 * served requester and registers the read data for AXI-Lite.
 */

`timescale 1ns/1ns

module aa_ctrl_result (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    input  logic                   exec_done,
    input  aa_ctrl_pkg::data_t     exec_rdata,
    input  aa_ctrl_pkg::src_e      exec_src,
    input  logic                   ss_hdr_ready,
    output logic                   bk_ls_ready,
    output aa_ctrl_pkg::data_t     bk_ls_rdata,
    output logic                   bk_ss_ready,
    output logic                   ls_done,
    output logic                   ss_done
);

    logic ls_hit;
    logic ss_hit;

    assign ls_hit = exec_done && (exec_src == aa_ctrl_pkg::src_ls);
    assign ss_hit = exec_done && (exec_src == aa_ctrl_pkg::src_ss);

    // ------------------------------------------------------------------
    // completion pulses and read data
    // ------------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            ls_done     <= 1'b0;
            ss_done     <= 1'b0;
            bk_ls_rdata <= '0;
        end else begin
            ls_done <= ls_hit;
            ss_done <= ss_hit;
            // rdata only carries a value in the ready cycle
            if (ls_hit) begin
                bk_ls_rdata <= exec_rdata;
            end else begin
                bk_ls_rdata <= '0;
            end
        end
    end

    assign bk_ls_ready = ls_done;

    // header acknowledge and final beat share the stream ready
    assign bk_ss_ready = ss_done | ss_hdr_ready;

endmodule

// ==== hw/aa_ctrl_top.sv ====
/*
 * AA register controller
 * Serves AXI-Lite slave and AXI-Stream slave backend requests
 * against the mailbox and AA control registers.
 */

`timescale 1ns/1ns

module aa_ctrl_top (
    input  logic                   axi_aclk,
    input  logic                   axi_aresetn,
    input  logic                   bk_ls_valid,
    input  logic                   bk_ls_rd_wr,
    input  aa_ctrl_pkg::ls_addr_t  bk_ls_addr,
    input  aa_ctrl_pkg::data_t     bk_ls_wdata,
    input  aa_ctrl_pkg::strb_t     bk_ls_wstrb,
    input  logic                   bk_ss_valid,
    input  aa_ctrl_pkg::data_t     bk_ss_data,
    input  logic [1:0]             bk_ss_user,
    output logic                   bk_ls_ready,
    output aa_ctrl_pkg::data_t     bk_ls_rdata,
    output logic                   bk_ss_ready,
    output logic                   axi_interrupt
);

    // decode to execute
    logic                  op_valid;
    aa_ctrl_pkg::op_e      op_kind;
    aa_ctrl_pkg::src_e     op_src;
    aa_ctrl_pkg::mb_idx_t  op_idx;
    aa_ctrl_pkg::data_t    op_wdata;
    aa_ctrl_pkg::strb_t    op_wstrb;
    logic                  ss_hdr_ready;

    // execute to result, and completion back to decode
    logic                  exec_done;
    aa_ctrl_pkg::data_t    exec_rdata;
    aa_ctrl_pkg::src_e     exec_src;
    logic                  ls_done;
    logic                  ss_done;

    aa_ctrl_decode i_decode (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .bk_ls_valid  (bk_ls_valid),
        .bk_ls_rd_wr  (bk_ls_rd_wr),
        .bk_ls_addr   (bk_ls_addr),
        .bk_ls_wdata  (bk_ls_wdata),
        .bk_ls_wstrb  (bk_ls_wstrb),
        .bk_ss_valid  (bk_ss_valid),
        .bk_ss_data   (bk_ss_data),
        .bk_ss_user   (bk_ss_user),
        .ls_done      (ls_done),
        .ss_done      (ss_done),
        .ss_hdr_ready (ss_hdr_ready),
        .op_valid     (op_valid),
        .op_kind      (op_kind),
        .op_src       (op_src),
        .op_idx       (op_idx),
        .op_wdata     (op_wdata),
        .op_wstrb     (op_wstrb)
    );

    aa_ctrl_execute i_execute (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .op_valid      (op_valid),
        .op_kind       (op_kind),
        .op_src        (op_src),
        .op_idx        (op_idx),
        .op_wdata      (op_wdata),
        .op_wstrb      (op_wstrb),
        .exec_done     (exec_done),
        .exec_rdata    (exec_rdata),
        .exec_src      (exec_src),
        .axi_interrupt (axi_interrupt)
    );

    aa_ctrl_result i_result (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .exec_done    (exec_done),
        .exec_rdata   (exec_rdata),
        .exec_src     (exec_src),
        .ss_hdr_ready (ss_hdr_ready),
        .bk_ls_ready  (bk_ls_ready),
        .bk_ls_rdata  (bk_ls_rdata),
        .bk_ss_ready  (bk_ss_ready),
        .ls_done      (ls_done),
        .ss_done      (ss_done)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the AA controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=aa_ctrl_sim

verilator --binary --timing --timescale 1ns/1ns -f sources.f \
    --top-module aa_ctrl_tb -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "RESULT: FAIL" "$log_file"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation finished without failures"
exit 0

// ==== sources.f ====
+incdir+hw
hw/aa_ctrl_pkg.sv
hw/aa_ctrl_decode.sv
hw/aa_ctrl_execute.sv
hw/aa_ctrl_result.sv
hw/aa_ctrl_top.sv
verification/aa_ctrl_tb.sv

// ==== verification/aa_ctrl_tb.sv ====
/*
 * AA register controller testbench
 * Drives AXI-Lite and AXI-Stream backend requests and checks read data,
 * ready timing and the interrupt line against a register model.
 */

`timescale 1ns/1ns

`include "aa_ctrl_consts.svh"

module aa_ctrl_tb;

    localparam int LS_LATENCY     = 3;
    localparam int DIRECTED_TRANS = 26;
    localparam int RANDOM_LS      = 200;
    // each random step may also issue one stream write
    localparam int TIMEOUT_CYCLES = 40 * (DIRECTED_TRANS + 2 * RANDOM_LS) + 100;

    logic                  axi_aclk = 1'b0;
    logic                  axi_aresetn;
    logic                  bk_ls_valid;
    logic                  bk_ls_rd_wr;
    aa_ctrl_pkg::ls_addr_t bk_ls_addr;
    aa_ctrl_pkg::data_t    bk_ls_wdata;
    aa_ctrl_pkg::strb_t    bk_ls_wstrb;
    logic                  bk_ss_valid;
    aa_ctrl_pkg::data_t    bk_ss_data;
    logic [1:0]            bk_ss_user;
    logic                  bk_ls_ready;
    aa_ctrl_pkg::data_t    bk_ls_rdata;
    logic                  bk_ss_ready;
    logic                  axi_interrupt;

    // register model
    aa_ctrl_pkg::data_t    mb_model [`AA_MB_COUNT];
    logic                  en_model;
    logic                  sts_model;

    // request in flight as seen by the compare process
    int                    cycle = 0;
    int                    seed = 32'h5d119702;
    logic                  ls_pend_rd;
    aa_ctrl_pkg::ls_addr_t ls_pend_addr;
    logic                  ls_timed;
    int                    ls_req_cycle;
    logic                  ss_final_expected = 1'b0;
    int                    ss_pulses = 0;
    int                    done_count = 0;
    int                    ls_done_order;
    int                    ss_done_order;
    aa_ctrl_pkg::data_t    exp_rdata;

    aa_ctrl_top i_dut (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .bk_ls_valid   (bk_ls_valid),
        .bk_ls_rd_wr   (bk_ls_rd_wr),
        .bk_ls_addr    (bk_ls_addr),
        .bk_ls_wdata   (bk_ls_wdata),
        .bk_ls_wstrb   (bk_ls_wstrb),
        .bk_ss_valid   (bk_ss_valid),
        .bk_ss_data    (bk_ss_data),
        .bk_ss_user    (bk_ss_user),
        .bk_ls_ready   (bk_ls_ready),
        .bk_ls_rdata   (bk_ls_rdata),
        .bk_ss_ready   (bk_ss_ready),
        .axi_interrupt (axi_interrupt)
    );

    always #2 axi_aclk = ~axi_aclk;

    always @(posedge axi_aclk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout: no completion after %0d cycles", cycle));
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input aa_ctrl_pkg::data_t got,
                              input aa_ctrl_pkg::data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------
    // register model
    // ------------------------------------------------------------------
    function automatic aa_ctrl_pkg::data_t expected_read(input aa_ctrl_pkg::ls_addr_t addr);
        if (addr >= `AA_MB_LOW && addr <= `AA_MB_HIGH) begin
            return mb_model[addr[4:2]];
        end else if (addr >= `AA_AA_LOW && addr <= `AA_AA_HIGH) begin
            return {{(`AA_DATA_W-1){1'b0}}, addr[2] ? sts_model : en_model};
        end
        return 32'hFFFF_FFFF;
    endfunction

    task automatic apply_ls_write(input aa_ctrl_pkg::ls_addr_t addr,
                                  input aa_ctrl_pkg::data_t wdata,
                                  input aa_ctrl_pkg::strb_t wstrb);
        if (addr >= `AA_MB_LOW && addr <= `AA_MB_HIGH) begin
            for (int b = 0; b < `AA_STRB_W; b++) begin
                if (wstrb[b]) begin
                    mb_model[addr[4:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (addr >= `AA_AA_LOW && addr <= `AA_AA_HIGH && wstrb[0]) begin
            if (!addr[2]) begin
                en_model = wdata[0];
            end else if (wdata[0]) begin
                sts_model = 1'b0;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // request drivers
    // ------------------------------------------------------------------
    task automatic ls_access(input logic rd, input aa_ctrl_pkg::ls_addr_t addr,
                             input aa_ctrl_pkg::data_t wdata, input aa_ctrl_pkg::strb_t wstrb,
                             input logic timed, output aa_ctrl_pkg::data_t rdata);
        @(posedge axi_aclk);
        bk_ls_valid <= 1'b1;
        bk_ls_rd_wr <= rd;
        bk_ls_addr  <= addr;
        bk_ls_wdata <= wdata;
        bk_ls_wstrb <= wstrb;
        ls_pend_rd   = rd;
        ls_pend_addr = addr;
        ls_timed     = timed;
        ls_req_cycle = cycle;
        if (!rd) begin
            apply_ls_write(addr, wdata, wstrb);
        end
        @(negedge axi_aclk);
        while (!bk_ls_ready) @(negedge axi_aclk);
        rdata = bk_ls_rdata;
        @(posedge axi_aclk);
        bk_ls_valid <= 1'b0;
    endtask

    task automatic ss_write(input logic [27:0] addr, input aa_ctrl_pkg::strb_t strb,
                            input aa_ctrl_pkg::data_t data, input logic [1:0] gap);
        @(posedge axi_aclk);
        bk_ss_valid <= 1'b1;
        bk_ss_data  <= {strb, addr};
        bk_ss_user  <= `AA_TUSER_WRITE;
        ss_pulses = 0;
        @(negedge axi_aclk);
        while (!bk_ss_ready) @(negedge axi_aclk);
        @(posedge axi_aclk);
        // model takes the write once the header is accepted
        if (addr >= 28'h0002000 && addr <= 28'h000201F) begin
            for (int b = 0; b < `AA_STRB_W; b++) begin
                if (strb[b]) begin
                    mb_model[addr[4:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
            sts_model = 1'b1;
        end
        ss_final_expected = 1'b1;
        if (gap != 2'd0) begin
            bk_ss_valid <= 1'b0;
            repeat (gap) @(posedge axi_aclk);
        end
        bk_ss_valid <= 1'b1;
        bk_ss_data  <= data;
        @(negedge axi_aclk);
        while (!bk_ss_ready) @(negedge axi_aclk);
        @(posedge axi_aclk);
        bk_ss_valid <= 1'b0;
        ss_final_expected = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // compare process sampling on the falling edge
    // ------------------------------------------------------------------
    always @(negedge axi_aclk) begin
        if (axi_aresetn) begin
            if (bk_ls_ready) begin
                exp_rdata = ls_pend_rd ? expected_read(ls_pend_addr) : '0;
                check_data("bk_ls_rdata", bk_ls_rdata, exp_rdata);
                check_bit("axi_interrupt", axi_interrupt, en_model & sts_model);
                if (ls_timed && cycle != ls_req_cycle + 1 + LS_LATENCY) begin
                    stop_on_error($sformatf(
                        "mismatch bk_ls_ready latency: got 0x%0h expected 0x%0h",
                        cycle - ls_req_cycle - 1, LS_LATENCY));
                end
                ls_done_order = done_count;
                done_count++;
            end
            if (bk_ss_ready) begin
                ss_pulses++;
                if (ss_final_expected) begin
                    check_bit("axi_interrupt", axi_interrupt, en_model & sts_model);
                    if (ss_pulses != 2) begin
                        stop_on_error($sformatf(
                            "mismatch bk_ss_ready pulses: got 0x%0h expected 0x2",
                            ss_pulses));
                    end
                    ss_done_order = done_count;
                    done_count++;
                end
            end
        end
    end

    initial begin
        aa_ctrl_pkg::data_t rd;
        logic [31:0]        sel;
        for (int i = 0; i < `AA_MB_COUNT; i++) begin
            mb_model[i] = '0;
        end
        en_model  = 1'b0;
        sts_model = 1'b0;
        axi_aresetn <= 1'b0;
        bk_ls_valid <= 1'b0;
        bk_ls_rd_wr <= 1'b0;
        bk_ls_addr  <= '0;
        bk_ls_wdata <= '0;
        bk_ls_wstrb <= '0;
        bk_ss_valid <= 1'b0;
        bk_ss_data  <= '0;
        bk_ss_user  <= 2'b00;
        repeat (2) @(posedge axi_aclk);
        axi_aresetn <= 1'b1;

        // first tie after reset goes to AXI-Lite
        fork
            ls_access(1'b1, 15'h2000, '0, '0, 1'b1, rd);
            ss_write(28'h0002004, 4'hF, 32'h1111_0001, 2'd1);
        join
        if (ls_done_order > ss_done_order) begin
            stop_on_error("AXI-Stream write was served before AXI-Lite on the first tie");
        end
        // stream side wins the next tie after AXI-Lite was served last
        ls_access(1'b1, 15'h2104, '0, '0, 1'b1, rd);
        fork
            ls_access(1'b1, 15'h200C, '0, '0, 1'b0, rd);
            ss_write(28'h000200C, 4'b0011, 32'hBEEF_CAFE, 2'd0);
        join
        if (ss_done_order > ls_done_order) begin
            stop_on_error("AXI-Lite read was served before AXI-Stream on the second tie");
        end
        check_data("bk_ls_rdata", rd, 32'h0000_CAFE);

        // mailbox partial strobes
        ls_access(1'b0, 15'h2008, 32'hA5A5_5A5A, 4'hF, 1'b1, rd);
        ls_access(1'b0, 15'h2008, 32'h1122_3344, 4'b0101, 1'b1, rd);
        ls_access(1'b1, 15'h2008, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'hA522_5A44);

        // enable keeps only bit 0 and status clears on a written one
        ls_access(1'b0, 15'h2100, 32'hFFFF_FFFF, 4'hF, 1'b1, rd);
        ls_access(1'b1, 15'h2100, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'h0000_0001);
        ls_access(1'b0, 15'h2100, 32'h0, 4'b1110, 1'b1, rd);
        ls_access(1'b0, 15'h2104, 32'hFFFF_FFFE, 4'hF, 1'b1, rd);
        ls_access(1'b1, 15'h2104, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'h0000_0001);
        ls_access(1'b0, 15'h2104, 32'h1, 4'h1, 1'b1, rd);
        ls_access(1'b1, 15'h2104, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'h0000_0000);
        ls_access(1'b0, 15'h2100, 32'hFFFF_FFFE, 4'hF, 1'b1, rd);

        // unsupported and out of range
        ls_access(1'b1, 15'h2200, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'hFFFF_FFFF);
        ls_access(1'b1, 15'h4000, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'hFFFF_FFFF);
        ls_access(1'b0, 15'h2200, 32'h5A5A_A5A5, 4'hF, 1'b1, rd);
        ls_access(1'b1, 15'h2000, '0, '0, 1'b1, rd);
        ls_access(1'b1, 15'h2100, '0, '0, 1'b1, rd);

        // remote mailbox writes and the interrupt
        ss_write(28'h0002014, 4'hF, 32'hC0DE_0005, 2'd3);
        ls_access(1'b1, 15'h2014, '0, '0, 1'b1, rd);
        check_data("bk_ls_rdata", rd, 32'hC0DE_0005);
        ls_access(1'b0, 15'h2100, 32'h1, 4'h1, 1'b1, rd);
        check_bit("axi_interrupt", axi_interrupt, 1'b1);
        ls_access(1'b0, 15'h2104, 32'h1, 4'h1, 1'b1, rd);
        check_bit("axi_interrupt", axi_interrupt, 1'b0);
        ss_write(28'h0002018, 4'b1100, 32'hDEAD_BEEF, 2'd2);
        check_bit("axi_interrupt", axi_interrupt, 1'b1);

        // random mix
        for (int n = 0; n < RANDOM_LS; n++) begin
            sel = $random(seed);
            if (sel[15:14] == 2'd0) begin
                ss_write(28'h0002000 | {23'd0, sel[20:18], 2'b00}, sel[24:21],
                         $random(seed), sel[13:12]);
            end
            if (sel[3:1] == 3'd0) begin
                ls_access(sel[0], `AA_AA_LOW | {12'd0, sel[4], 2'b00}, $random(seed),
                          sel[11:8], 1'b1, rd);
            end else begin
                ls_access(sel[0], `AA_MB_LOW | {10'd0, sel[7:5], 2'b00}, $random(seed),
                          sel[11:8], 1'b1, rd);
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule
